// File: testbench/fpu_stim.txt
# test  op(0 add, 1 sub, 2 mul)  a  b  expected  stall
# expected values use truncation, no rounding
1 0 3F800000 3F800000 40000000 0
2 0 3FC00000 3F400000 40100000 0
3 0 3F800000 2B800000 3F800000 0
4 0 3F800000 33800000 3F800000 0
5 1 3F800000 3F400000 3E800000 0
6 1 3F800001 3F800000 34000000 0
7 0 3F800000 BFC00000 BF000000 0
8 1 40000000 40400000 BF800000 3
9 2 3FC00000 3FA00000 3FF00000 2
10 2 3FC00000 3FC00000 40100000 0
11 2 C0000000 40400000 C0C00000 4
12 2 3F800001 3F800001 3F800002 1

// File: fpu.f
+incdir+rtl
rtl/fpuPkg.sv
rtl/fpuOpIf.sv
rtl/leadingOneDetect.sv
rtl/operandStage.sv
rtl/addSubUnit.sv
rtl/mulUnit.sv
rtl/resultStage.sv
rtl/fpuTop.sv
testbench/fpuChecker.sv
testbench/fpuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the FPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f fpu.f --top-module fpuTb -o fpuSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/fpuSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
	exit 1
fi
exit 0

// File: testbench/fpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int HalfPeriod = 10
) (
	output logic clk
);

	initial clk = 1'b0;
	always #HalfPeriod clk = ~clk;

endmodule

module fpuTb import fpuPkg::*; ();

	localparam int Timeout = 200;

	logic clk;
	logic reset;
	logic inValid;
	logic inReady;
	fpuOpT inOp;
	floatT inA;
	floatT inB;
	logic outValid;
	logic outReady;
	floatT outResult;

	logic checkDone;
	int checkErrors;
	int checkTests;
	int driverErrors;

	int numQ[$];
	logic [1:0] opQ[$];
	floatT aQ[$];
	floatT bQ[$];

	tbClock clock (.clk(clk));

	fpuTop UUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inOp(inOp),
		.inA(inA),
		.inB(inB),
		.outValid(outValid),
		.outReady(outReady),
		.outResult(outResult)
	);

	fpuChecker fpuChecker (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.outValid(outValid),
		.outReady(outReady),
		.outResult(outResult),
		.done(checkDone),
		.errorCount(checkErrors),
		.testCount(checkTests)
	);

	task automatic loadStimulus();
		int fd;
		string line;
		int num;
		logic [1:0] op;
		floatT a;
		floatT b;
		floatT expected;
		int stall;
		fd = $fopen("testbench/fpu_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			driverErrors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line.getc(0) != "#") begin
				if ($sscanf(line, "%d %d %h %h %h %d", num, op, a, b, expected, stall) == 6) begin
					numQ.push_back(num);
					opQ.push_back(op);
					aQ.push_back(a);
					bQ.push_back(b);
				end
			end
		end
		$fclose(fd);
	endtask

	// Driven on the falling edge so the transfer lands on the next rising edge
	task automatic sendOp(input int idx, output bit accepted);
		int waited;
		@(negedge clk);
		inValid = 1'b1;
		inOp = fpuOpT'(opQ[idx]);
		inA = aQ[idx];
		inB = bQ[idx];
		accepted = 0;
		waited = 0;
		while (!accepted && waited < Timeout) begin
			#1;
			if (inReady) begin
				@(posedge clk);
				accepted = 1;
			end else begin
				@(negedge clk);
				waited++;
			end
		end
	endtask

	initial begin
		bit accepted;
		int waited;
		reset = 1'b1;
		inValid = 1'b0;
		inOp = opAdd;
		inA = '0;
		inB = '0;
		driverErrors = 0;
		loadStimulus();
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < numQ.size(); i++) begin
			sendOp(i, accepted);
			if (!accepted) begin
				$display("driver timed out waiting for inReady on test %0d", numQ[i]);
				driverErrors++;
				break;
			end
		end
		@(negedge clk);
		inValid = 1'b0;
		waited = 0;
		while (checkDone !== 1'b1 && waited < 2000) begin
			@(posedge clk);
			waited++;
		end
		if (checkDone !== 1'b1) begin
			$display("checker did not finish before the timeout");
			$display("FAIL: see errors above");
		end else begin
			$display("%0d tests checked, %0d errors", checkTests, checkErrors + driverErrors);
			if (checkErrors + driverErrors == 0) begin
				$display("PASS: all tests");
			end else begin
				$display("FAIL: see errors above");
			end
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/fpuChecker.sv
`timescale 1ns/1ps
`default_nettype none

module fpuChecker import fpuPkg::*; (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic inReady,
	input logic outValid,
	output logic outReady,
	input floatT outResult,
	output logic done,
	output int errorCount,
	output int testCount
);

	localparam int Timeout = 200;

	int testQ[$];
	floatT expectQ[$];
	int stallQ[$];
	int cycle = 0;
	int acceptEdge;
	bit sawInStall;
	bit wantStall;

	always @(posedge clk) cycle <= cycle + 1;

	task automatic loadExpected();
		int fd;
		string line;
		int num;
		logic [1:0] op;
		floatT a;
		floatT b;
		floatT expected;
		int stall;
		fd = $fopen("testbench/fpu_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			errorCount++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line.getc(0) != "#") begin
				if ($sscanf(line, "%d %d %h %h %h %d", num, op, a, b, expected, stall) == 6) begin
					testQ.push_back(num);
					expectQ.push_back(expected);
					stallQ.push_back(stall);
					if (stall >= 2) begin
						wantStall = 1;
					end
				end
			end
		end
		$fclose(fd);
	endtask

	// Reset idle state, acceptance times and input stalls
	initial begin : watch
		int guard;
		bit afterReset;
		acceptEdge = -1;
		sawInStall = 0;
		afterReset = 0;
		guard = 0;
		while (done !== 1'b1 && guard < 10000) begin
			@(negedge clk);
			#1;
			guard++;
			if (reset || !afterReset) begin
				if (outValid !== 1'b0 || inReady !== 1'b1) begin
					$display("MISMATCH at %0t: outValid %b inReady %b during or right after reset",
						$time, outValid, inReady);
					errorCount++;
				end
				afterReset = !reset;
			end
			if (inValid && inReady && acceptEdge < 0) begin
				acceptEdge = cycle + 1;
			end
			if (inValid && !inReady) begin
				sawInStall = 1;
			end
		end
	end

	initial begin : compare
		int waited;
		bit received;
		floatT got;
		outReady = 1;
		done = 0;
		errorCount = 0;
		testCount = 0;
		wantStall = 0;
		loadExpected();
		#1;
		waited = 0;
		while (reset !== 1'b0 && waited < Timeout) begin
			@(negedge clk);
			#1;
			waited++;
		end
		for (int idx = 0; idx < testQ.size(); idx++) begin
			for (int k = 0; k < stallQ[idx]; k++) begin
				@(negedge clk);
				outReady = 0;
			end
			@(negedge clk);
			outReady = 1;
			waited = 0;
			received = 0;
			while (!received && waited < Timeout) begin
				#1;
				if (outValid) begin
					got = outResult;
					if (idx == 0 && cycle + 1 - acceptEdge != 2) begin
						$display("test %0d latency was %0d cycles instead of 2",
							testQ[idx], cycle + 1 - acceptEdge);
						errorCount++;
					end
					@(posedge clk);
					received = 1;
				end else begin
					@(negedge clk);
					waited++;
				end
			end
			if (!received) begin
				$display("timed out waiting for the result of test %0d", testQ[idx]);
				errorCount++;
				break;
			end
			testCount++;
			if (got !== expectQ[idx]) begin
				$display("MISMATCH at %0t: test %0d expected %h got %h",
					$time, testQ[idx], expectQ[idx], got);
				errorCount++;
			end else begin
				$display("test %0d ok, result %h", testQ[idx], got);
			end
		end
		if (wantStall && !sawInStall) begin
			$display("inReady never fell while the output was stalled");
			errorCount++;
		end
		done = 1;
	end

endmodule

`default_nettype wire

// File: rtl/fpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module fpuTop import fpuPkg::*; (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input fpuOpT inOp,
	input floatT inA,
	input floatT inB,
	output logic outValid,
	input logic outReady,
	output floatT outResult
);

	fpuOpIf opBus ();

	floatT sumResult;
	floatT productResult;
	logic subtract;

	assign subtract = (opBus.op == opSub);

	operandStage operands (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inOp(inOp),
		.inA(inA),
		.inB(inB),
		.opBus(opBus.source)
	);

	addSubUnit addSub (
		.subtract(subtract),
		.opBus(opBus.operands),
		.sum(sumResult)
	);

	mulUnit mul (
		.opBus(opBus.operands),
		.product(productResult)
	);

	resultStage result (
		.clk(clk),
		.reset(reset),
		.opBus(opBus.sink),
		.sum(sumResult),
		.product(productResult),
		.outValid(outValid),
		.outReady(outReady),
		.outResult(outResult)
	);

endmodule

`default_nettype wire

// File: rtl/resultStage.sv
`timescale 1ns/1ps
`default_nettype none

module resultStage import fpuPkg::*; (
	input logic clk,
	input logic reset,
	fpuOpIf.sink opBus,
	input floatT sum,
	input floatT product,
	output logic outValid,
	input logic outReady,
	output floatT outResult
);

	logic outFull;
	logic outFree;
	floatT resultReg;
	floatT selected;

	// Empty or being read this edge
	assign outFree = !outFull || outReady;

	assign opBus.advance = opBus.valid && outFree;

	assign selected = (opBus.op == opMul) ? product : sum;

	always_ff @(posedge clk) begin
		if (reset) begin
			outFull <= 1'b0;
		end else if (outFree) begin
			outFull <= opBus.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (opBus.advance) begin
			resultReg <= selected;
		end
	end

	assign outValid = outFull;
	assign outResult = resultReg;

	// Stalled result stays put until taken
	outStable: assert property (@(posedge clk) disable iff (reset)
		outValid && !outReady |=> outValid && $stable(outResult));

endmodule

`default_nettype wire

// File: rtl/mulUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module mulUnit import fpuPkg::*; (
	fpuOpIf.operands opBus,
	output floatT product
);

	localparam int SignBit = `FPU_EXP_WIDTH + `FPU_FRAC_WIDTH;
	localparam int ProdWidth = 2 * (`FPU_FRAC_WIDTH + 1);
	localparam int PosWidth = $clog2(ProdWidth);
	localparam logic [PosWidth-1:0] TopPos = PosWidth'(ProdWidth - 1);

	expT expA;
	expT expB;
	sigT sigA;
	sigT sigB;

	logic [ProdWidth-1:0] prodRaw;
	logic [ProdWidth-1:0] prodNorm;
	logic [PosWidth-1:0] leadPos;
	logic carry;

	expT resultExp;
	fracT resultFrac;
	logic resultSign;

	assign expA = opBus.a[SignBit-1:`FPU_FRAC_WIDTH];
	assign expB = opBus.b[SignBit-1:`FPU_FRAC_WIDTH];
	assign sigA = {1'b1, opBus.a[`FPU_FRAC_WIDTH-1:0]};
	assign sigB = {1'b1, opBus.b[`FPU_FRAC_WIDTH-1:0]};

	assign prodRaw = ProdWidth'(sigA) * ProdWidth'(sigB);

	// Leading one lands on bit 46 or 47 for normal inputs
	leadingOneDetect #(
		.Width(ProdWidth)
	) prodLeadOne (
		.value(prodRaw),
		.position(leadPos)
	);

	assign carry = (leadPos == TopPos);
	assign prodNorm = prodRaw << (TopPos - leadPos);
	assign resultFrac = prodNorm[ProdWidth-2 -: `FPU_FRAC_WIDTH];

	// Wraps mod 256, no range check
	assign resultExp = expA + expB - expT'(`FPU_BIAS) + expT'(carry);

	assign resultSign = opBus.a[SignBit] ^ opBus.b[SignBit];

	assign product = {resultSign, resultExp, resultFrac};

endmodule

`default_nettype wire

// File: rtl/addSubUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module addSubUnit import fpuPkg::*; (
	input logic subtract,
	fpuOpIf.operands opBus,
	output floatT sum
);

	localparam int SignBit = `FPU_EXP_WIDTH + `FPU_FRAC_WIDTH;
	localparam int AlignWidth = `FPU_ALIGN_WIDTH;
	localparam int PosWidth = $clog2(AlignWidth);
	localparam logic [PosWidth-1:0] TopPos = PosWidth'(AlignWidth - 1);
	// Leading one position of an unshifted sum with no carry out
	localparam int NormPos = AlignWidth - 2;

	logic signA;
	logic signB;
	expT expA;
	expT expB;
	fracT fracA;
	fracT fracB;

	logic swap;
	logic effSub;
	logic resultSign;
	expT bigExp;
	expT smallExp;
	expT shiftAmount;
	fracT bigFrac;
	fracT smallFrac;

	logic [AlignWidth-1:0] bigField;
	logic [AlignWidth-1:0] smallField;
	logic [AlignWidth-1:0] shiftedField;
	logic [AlignWidth:0] rawSum;
	logic [AlignWidth-1:0] normField;
	logic [AlignWidth-1:0] normShifted;
	logic [PosWidth-1:0] leadPos;

	expT resultExp;
	fracT resultFrac;

	assign signA = opBus.a[SignBit];
	assign signB = opBus.b[SignBit];
	assign expA = opBus.a[SignBit-1:`FPU_FRAC_WIDTH];
	assign expB = opBus.b[SignBit-1:`FPU_FRAC_WIDTH];
	assign fracA = opBus.a[`FPU_FRAC_WIDTH-1:0];
	assign fracB = opBus.b[`FPU_FRAC_WIDTH-1:0];

	// B leads on larger exponent, or larger fraction at equal exponents
	assign swap = (expB > expA) || ((expB == expA) && (fracB > fracA));

	assign bigExp = swap ? expB : expA;
	assign smallExp = swap ? expA : expB;
	assign bigFrac = swap ? fracB : fracA;
	assign smallFrac = swap ? fracA : fracB;
	assign shiftAmount = bigExp - smallExp;

	assign effSub = subtract ^ signA ^ signB;
	assign resultSign = swap ? (signB ^ subtract) : signA;

	assign bigField = {1'b1, bigFrac, {`FPU_GUARD_WIDTH{1'b0}}};
	assign smallField = {1'b1, smallFrac, {`FPU_GUARD_WIDTH{1'b0}}};

	// Smaller operand vanishes past the field width
	assign shiftedField = (shiftAmount >= expT'(AlignWidth)) ? '0 : (smallField >> shiftAmount);

	assign rawSum = effSub ? ({1'b0, bigField} - {1'b0, shiftedField})
		: ({1'b0, bigField} + {1'b0, shiftedField});

	// LSB dropped, carry kept on top
	assign normField = rawSum[AlignWidth:1];

	leadingOneDetect #(
		.Width(AlignWidth)
	) sumLeadOne (
		.value(normField),
		.position(leadPos)
	);

	assign normShifted = normField << (TopPos - leadPos);
	assign resultFrac = normShifted[AlignWidth-2 -: `FPU_FRAC_WIDTH];
	assign resultExp = bigExp + expT'(leadPos) - expT'(NormPos);

	assign sum = {resultSign, resultExp, resultFrac};

endmodule

`default_nettype wire

// File: rtl/operandStage.sv
`timescale 1ns/1ps
`default_nettype none

module operandStage import fpuPkg::*; (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input fpuOpT inOp,
	input floatT inA,
	input floatT inB,
	fpuOpIf.source opBus
);

	logic held;
	fpuOpT opReg;
	floatT aReg;
	floatT bReg;

	// Room when empty or when the held op leaves this edge
	assign inReady = !held || opBus.advance;

	always_ff @(posedge clk) begin
		if (reset) begin
			held <= 1'b0;
		end else if (inReady) begin
			held <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			opReg <= inOp;
			aReg <= inA;
			bReg <= inB;
		end
	end

	assign opBus.valid = held;
	assign opBus.op = opReg;
	assign opBus.a = aReg;
	assign opBus.b = bReg;

	holdStable: assert property (@(posedge clk) disable iff (reset)
		held && !opBus.advance |=> $stable(opReg) && $stable(aReg) && $stable(bReg));

endmodule

`default_nettype wire

// File: rtl/leadingOneDetect.sv
`timescale 1ns/1ps
`default_nettype none

module leadingOneDetect #(
	parameter int Width = 32
) (
	input logic [Width-1:0] value,
	output logic [$clog2(Width)-1:0] position
);

	localparam int PosWidth = $clog2(Width);

	// Scan upward so the highest set bit wins
	always_comb begin
		position = '0;
		for (int i = 0; i < Width; i++) begin
			if (value[i]) begin
				position = PosWidth'(i);
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/fpuOpIf.sv
`timescale 1ns/1ps
`default_nettype none

interface fpuOpIf import fpuPkg::*;;

	logic valid;
	fpuOpT op;
	floatT a;
	floatT b;

	// Held operation moves into the result register this edge
	logic advance;

	modport source (output valid, output op, output a, output b, input advance);

	modport sink (input valid, input op, input a, input b, output advance);

	// Datapaths only look at the operands
	modport operands (input a, input b);

endinterface

`default_nettype wire

// File: rtl/fpuPkg.sv
`default_nettype none

`include "fpu_defines.svh"

package fpuPkg;

	// Sign, exponent, fraction
	typedef logic [`FPU_EXP_WIDTH+`FPU_FRAC_WIDTH:0] floatT;

	typedef logic [`FPU_EXP_WIDTH-1:0] expT;
	typedef logic [`FPU_FRAC_WIDTH-1:0] fracT;

	// Fraction with the hidden one on top
	typedef logic [`FPU_FRAC_WIDTH:0] sigT;

	typedef enum logic [1:0] {
		opAdd = 2'd0,
		opSub = 2'd1,
		opMul = 2'd2
	} fpuOpT;

endpackage

`default_nettype wire

// File: rtl/fpu_defines.svh
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// IEEE-754 single precision layout
`define FPU_EXP_WIDTH 8
`define FPU_FRAC_WIDTH 23

`define FPU_BIAS 127

// Alignment field for add/sub
// Hidden one plus fraction, then guard bits
`define FPU_GUARD_WIDTH 8
`define FPU_ALIGN_WIDTH 32

`endif
